/* filelist.f */
+incdir+common
common/scan_geom_pkg.sv
common/scan_cmd_pkg.sv
common/scan_pos_if.sv
hdl/cmd_deser.sv
scanline/scanline_regs.sv
scanline/scanline_ctrl.sv
scanline/scanline_addr_pipe.sv
scanline/scanline_len_calc.sv
hdl/scanline_rw.sv
verification/tb_scanline_rw.sv

/* verification/tb_scanline_rw.sv */
// directed testbench for scanline_rw, 100 ns clock, reset held 8 cycles
// descriptors are checked against a model of the length and address rules
// random windows keep x0 + width below 8192 and the address inside 22 bits
`timescale 1ns/1ns
`include "scanline_macros.svh"

module tb_scanline_rw;
    import scan_geom_pkg::*;
    import scan_cmd_pkg::*;

    logic        rst;
    logic        mclk;
    logic [7:0]  cmd_ad;
    logic        cmd_stb;
    logic        frame_start;
    logic        next_page;
    logic        frame_done;
    logic        suspend;
    logic        xfer_want;
    logic        xfer_need;
    logic        xfer_grant;
    logic        xfer_start;
    logic [2:0]  xfer_bank;
    logic [14:0] xfer_row;
    logic [6:0]  xfer_col;
    logic [5:0]  xfer_num128;
    logic        xfer_done;
    logic        xfer_reset_page;

    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          fd_count = 0;          // frame_done pulses seen
    int          tb_free;               // free pages as the testbench counts them
    logic [31:0] lfsr = 32'h6ae1;
    int          win_w;
    int          win_h;
    int          win_x0;
    int          win_y0;
    int          full_w;
    int          start_a;
    rc_addr_t    exp_rc [$];
    bank_t       exp_bank [$];
    xfer_len_t   exp_len [$];
    rc_addr_t    last_rc;               // descriptor captured with xfer_start
    bank_t       last_bank;
    xfer_len_t   last_len;

    scanline_rw i_scanline_rw (.*);

    initial begin
        mclk = 1'b0;
        forever #50 mclk = ~mclk;
    end

    always @(posedge mclk)
        if (frame_done)
            fd_count <= fd_count + 1;

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        logic        fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_rc(input string name, input rc_addr_t got, input rc_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bank(input string name, input bank_t got, input bank_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_len(input string name, input xfer_len_t got, input xfer_len_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // six bytes AL, AH, D0..D3, then cmd_we, register load and control reaction
    task automatic write_reg(input logic [15:0] addr, input cmd_data_t data);
        logic [47:0] cmd_w;
        cmd_w = {data, addr};
        for (int i = 0; i < 6; i++) begin
            @(posedge mclk);
            cmd_ad  <= cmd_w[8*i +: 8];
            cmd_stb <= (i == 0);          // strobe with AL only
        end
        @(posedge mclk);
        cmd_ad  <= '0;
        cmd_stb <= 1'b0;
        repeat (3) @(posedge mclk);
    endtask

    task automatic set_reg(input scan_reg_e r, input cmd_data_t data);
        write_reg(16'(`SCAN_CMD_BASE) + 16'(r), data);
    endtask

    task automatic program_window(input int sa, input int fw, input int w, input int h,
                                  input int x0, input int y0);
        start_a = sa;
        full_w  = fw;
        win_w   = w;
        win_h   = h;
        win_x0  = x0;
        win_y0  = y0;
        set_reg(START_ADDR, cmd_data_t'(sa));
        set_reg(FULL_WIDTH, cmd_data_t'(fw));
        set_reg(WINDOW_WH, {16'(h), 16'(w)});     // height high, width low
        set_reg(WINDOW_X0Y0, {16'(y0), 16'(x0)});
    endtask

    // scan-line walk, each transfer min(64, rest of line, rest of 128-burst page)
    task automatic build_model();
        int x;
        int fx;
        int fy;
        int len;
        exp_rc.delete();
        exp_bank.delete();
        exp_len.delete();
        for (int y = 0; y < win_h; y++) begin
            x = 0;
            while (x < win_w) begin
                fx  = x + win_x0;
                fy  = y + win_y0;
                len = 64;
                if (win_w - x < len)
                    len = win_w - x;
                if (128 - fx % 128 < len)
                    len = 128 - fx % 128;             // page boundary
                exp_rc.push_back(rc_addr_t'(start_a + (fy / 8) * full_w + fx));
                exp_bank.push_back(bank_t'(fy % 8));
                exp_len.push_back(xfer_len_t'(len));
                x += len;
            end
        end
    endtask

    task automatic start_frame(input logic [1:0] extra);
        set_reg(MODE, {28'd0, extra, 2'b01});          // running, not enabled
        @(posedge mclk);
        frame_start <= 1'b1;
        @(posedge mclk);
        frame_start <= 1'b0;
        set_reg(MODE, {28'd0, extra, 2'b11});
        tb_free = `SCAN_BUF_PAGES;
    endtask

    task automatic wait_want(output bit seen);
        seen = 1'b0;
        for (int n = 0; n < 300 && !seen; n++) begin
            @(posedge mclk);
            seen = xfer_want;
        end
        if (!seen) begin
            errors++;
            $display("timeout, xfer_want did not rise within 300 cycles at %0t", $time);
        end
    endtask

    // grant after a random delay, capture the descriptor, answer with xfer_done
    task automatic grant_one(input logic with_page, output bit ok);
        wait_want(ok);
        if (!ok)
            return;
        check_bit("xfer_need", xfer_need, tb_free >= 3);
        repeat (rand_bits(3)) @(posedge mclk);
        check_bit("xfer_want", xfer_want, 1'b1);      // held until grant
        xfer_grant <= 1'b1;
        @(posedge mclk);
        xfer_grant <= 1'b0;
        @(posedge mclk);
        check_bit("xfer_start", xfer_start, 1'b1);
        check_bit("xfer_want", xfer_want, 1'b0);
        check_bit("xfer_need", xfer_need, 1'b0);
        last_rc   = {xfer_row, xfer_col};
        last_bank = xfer_bank;
        last_len  = (xfer_num128 == '0) ? xfer_len_t'(64) : xfer_len_t'(xfer_num128);
        xfer_done <= 1'b1;
        next_page <= with_page;
        @(posedge mclk);
        check_bit("xfer_start", xfer_start, 1'b0);    // single-cycle pulse
        xfer_done <= 1'b0;
        next_page <= 1'b0;
        tb_free = tb_free - 1 + int'(with_page);
    endtask

    task automatic run_frame();
        int  fd0;
        bit  ok;
        bit  stray;
        build_model();
        start_frame(2'd0);
        fd0 = fd_count;
        for (int i = 0; i < exp_len.size(); i++) begin
            grant_one(1'b1, ok);
            if (!ok)
                return;
            check_rc("xfer_row/xfer_col", last_rc, exp_rc[i]);
            check_bank("xfer_bank", last_bank, exp_bank[i]);
            check_len("xfer_num128", last_len, exp_len[i]);
            check_bit("frame_done held off", fd_count == fd0, 1'b1);
        end
        for (int n = 0; n < 50 && fd_count == fd0; n++)
            @(posedge mclk);
        if (fd_count == fd0) begin
            errors++;
            $display("timeout, no frame_done after the last xfer_done at %0t", $time);
            return;
        end
        stray = 1'b0;
        repeat (20) begin
            @(posedge mclk);
            stray |= xfer_want;                        // busy must be gone
        end
        check_bit("xfer_want after frame", stray, 1'b0);
        check_bit("single frame_done", fd_count == fd0 + 1, 1'b1);
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("test %-16s %s", name, (errors == err0) ? "ok" : "with errors");
    endtask

    task automatic reset_defaults();
        int err0;
        err0 = errors;
        @(posedge mclk);
        check_bit("xfer_want", xfer_want, 1'b0);
        check_bit("xfer_need", xfer_need, 1'b0);
        check_bit("xfer_start", xfer_start, 1'b0);
        check_bit("frame_done", frame_done, 1'b0);
        check_bit("xfer_reset_page", xfer_reset_page, 1'b1);
        set_reg(MODE, 32'h1);
        check_bit("xfer_reset_page", xfer_reset_page, 1'b0);
        report_test("reset", err0);
    endtask

    task automatic single_line_split();
        int        err0;
        xfer_len_t split [0:3] = '{28, 64, 64, 44};
        err0 = errors;
        program_window(22'h01000, 512, 200, 1, 100, 13);
        build_model();
        check_bit("transfer count 4", exp_len.size() == 4, 1'b1);
        for (int i = 0; i < 4 && i < exp_len.size(); i++)
            check_len("model split", exp_len[i], split[i]);
        run_frame();
        report_test("single_line", err0);
    endtask

    task automatic multi_line_window();
        int err0;
        int x0;
        int w;
        err0 = errors;
        x0 = rand_bits(10);
        w  = 1 + rand_bits(8);
        program_window(rand_bits(16), x0 + w + rand_bits(9), w, 3 + rand_bits(2), x0,
                       rand_bits(8));
        run_frame();
        report_test("multi_line", err0);
    endtask

    task automatic page_back_pressure();
        int err0;
        bit ok;
        bit stray;
        err0 = errors;
        program_window(0, 1024, 512, 2, 0, 0);
        start_frame(2'd2);
        grant_one(1'b0, ok);
        grant_one(1'b0, ok);
        stray = 1'b0;
        repeat (40) begin
            @(posedge mclk);
            stray |= xfer_want;                        // two pages free, two held
        end
        check_bit("xfer_want at 2 free", stray, 1'b0);
        @(posedge mclk);
        next_page <= 1'b1;
        @(posedge mclk);
        next_page <= 1'b0;
        tb_free++;
        grant_one(1'b0, ok);                           // need expected with 3 free
        set_reg(MODE, {28'd0, 2'd1, 2'b11});
        grant_one(1'b0, ok);                           // 2 free, want without need
        set_reg(MODE, 32'h0);
        report_test("back_pressure", err0);
    endtask

    task automatic suspend_and_abort();
        int err0;
        int fd0;
        bit ok;
        bit stray;
        err0 = errors;
        program_window(22'h2000, 256, 300, 4, 20, 3);
        @(posedge mclk);
        suspend <= 1'b1;
        start_frame(2'd0);
        stray = 1'b0;
        repeat (40) begin
            @(posedge mclk);
            stray |= xfer_want;
        end
        check_bit("xfer_want while suspended", stray, 1'b0);
        suspend <= 1'b0;
        grant_one(1'b1, ok);
        wait_want(ok);
        fd0 = fd_count;
        set_reg(MODE, 32'h0);                          // channel reset mid-frame
        check_bit("xfer_want", xfer_want, 1'b0);
        check_bit("xfer_need", xfer_need, 1'b0);
        check_bit("xfer_reset_page", xfer_reset_page, 1'b1);
        stray = 1'b0;
        repeat (40) begin
            @(posedge mclk);
            stray |= xfer_want | frame_done;
        end
        check_bit("want or frame_done after abort", stray, 1'b0);
        check_bit("no frame_done", fd_count == fd0, 1'b1);
        report_test("suspend_reset", err0);
    endtask

    task automatic address_filter();
        int err0;
        err0 = errors;
        program_window(22'h3c000, 700, 150, 2, 60, 40);
        run_frame();
        write_reg(16'(`SCAN_CMD_BASE) + 16'h10 + 16'(WINDOW_WH), {16'd1, 16'd50});
        run_frame();                                   // old window expected
        report_test("addr_filter", err0);
    endtask

    initial begin
        rst         = 1'b1;
        cmd_ad      = '0;
        cmd_stb     = 1'b0;
        frame_start = 1'b0;
        next_page   = 1'b0;
        suspend     = 1'b0;
        xfer_grant  = 1'b0;
        xfer_done   = 1'b0;
        repeat (8) @(posedge mclk);
        rst <= 1'b0;
        reset_defaults();
        single_line_split();
        multi_line_window();
        page_back_pressure();
        suspend_and_abort();
        address_filter();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* hdl/scanline_rw.sv */
// scan-line read sequencer for one ddr3 channel, read only
// descriptor outputs are valid from xfer_start, xfer_num128 of 0 means 64
// frames always start at the window origin
`timescale 1ns/1ns
`include "scanline_macros.svh"

module scanline_rw (
    input  logic                            rst,
    input  logic                            mclk,
    input  logic [7:0]                      cmd_ad,      // AL, AH, D0..D3
    input  logic                            cmd_stb,     // with AL
    input  logic                            frame_start,
    input  logic                            next_page,
    output logic                            frame_done,
    input  logic                            suspend,
    output logic                            xfer_want,
    output logic                            xfer_need,
    input  logic                            xfer_grant,
    output logic                            xfer_start,
    output logic [2:0]                      xfer_bank,
    output logic [`SCAN_ADDRESS_NUMBER-1:0] xfer_row,
    output logic [`SCAN_COLADDR_NUMBER-4:0] xfer_col,    // in 8-bursts
    output logic [`SCAN_XFER_BITS-1:0]      xfer_num128,
    input  logic                            xfer_done,
    output logic                            xfer_reset_page
);
    import scan_geom_pkg::*;
    import scan_cmd_pkg::*;

    cmd_addr_t  cmd_a;
    cmd_data_t  cmd_data;
    logic       cmd_we;
    scan_cfg_t  cfg;
    scan_mode_t mode;

    scan_pos_if pos_if ();

    assign xfer_bank   = pos_if.bank;
    assign xfer_row    = pos_if.row_col[RC_BITS-1:`SCAN_COLADDR_NUMBER-3];
    assign xfer_col    = pos_if.row_col[`SCAN_COLADDR_NUMBER-4:0];
    assign xfer_num128 = pos_if.xfer_num[`SCAN_XFER_BITS-1:0]; // 64 drops to 0

    cmd_deser i_cmd_deser (
        .rst      (rst),
        .mclk     (mclk),
        .cmd_ad   (cmd_ad),
        .cmd_stb  (cmd_stb),
        .cmd_a    (cmd_a),
        .cmd_data (cmd_data),
        .cmd_we   (cmd_we)
    );

    scanline_regs i_scanline_regs (
        .rst      (rst),
        .mclk     (mclk),
        .cmd_a    (cmd_a),
        .cmd_data (cmd_data),
        .cmd_we   (cmd_we),
        .cfg      (cfg),
        .mode     (mode)
    );

    scanline_ctrl i_scanline_ctrl (
        .rst             (rst),
        .mclk            (mclk),
        .mode            (mode),
        .cfg_write       (cmd_we),
        .frame_start     (frame_start),
        .next_page       (next_page),
        .suspend         (suspend),
        .xfer_grant      (xfer_grant),
        .xfer_done       (xfer_done),
        .frame_done      (frame_done),
        .xfer_want       (xfer_want),
        .xfer_need       (xfer_need),
        .xfer_start      (xfer_start),
        .xfer_reset_page (xfer_reset_page),
        .pos             (pos_if.ctrl)
    );

    scanline_len_calc i_scanline_len_calc (
        .mclk (mclk),
        .cfg  (cfg),
        .pos  (pos_if.len)
    );

    scanline_addr_pipe i_scanline_addr_pipe (
        .mclk (mclk),
        .cfg  (cfg),
        .pos  (pos_if.addr)
    );

endmodule

/* scanline/scanline_len_calc.sv */
// transfer length = min(64, bursts left in line, bursts left in 128-burst page)
// 4 cycles from curr_x/curr_y to xfer_num, last_in_row and last_row
`timescale 1ns/1ns
`include "scanline_macros.svh"

module scanline_len_calc (
    input  logic                     mclk,
    input  scan_geom_pkg::scan_cfg_t cfg,
    scan_pos_if.len                  pos
);
    import scan_geom_pkg::*;

    localparam int PB = `SCAN_COLADDR_NUMBER - 3;    // 7, page offset bits
    localparam int XB = `SCAN_XFER_BITS;
    localparam logic [PB:0] PAGE_SIZE = 1 << PB;     // 128 bursts
    localparam xfer_len_t   XFER_MAX  = 1 << XB;     // 64 bursts

    win_w_t      row_left;      // stage 1
    logic [PB-1:0] page_pos;    // frame_x inside the page
    win_h_t      next_y;
    logic [PB:0] page_left;     // stage 2
    xfer_len_t   lim_by_xfer;
    win_w_t      row_left_d;
    logic        last_row_d;
    xfer_len_t   num_r;         // stage 3
    win_w_t      row_left_dd;
    logic        last_row_dd;

    always_ff @(posedge mclk) begin
        row_left    <= cfg.window_width - win_w_t'(pos.curr_x);
        page_pos    <= pos.curr_x[PB-1:0] + cfg.window_x0[PB-1:0]; // wraps mod 128
        next_y      <= win_h_t'(pos.curr_y) + win_h_t'(1);
        page_left   <= PAGE_SIZE - {1'b0, page_pos};
        lim_by_xfer <= (|row_left[$bits(win_w_t)-1:XB]) ? XFER_MAX : row_left[XB:0];
        row_left_d  <= row_left;
        last_row_d  <= next_y == cfg.window_height;
        num_r       <= (page_left > {1'b0, lim_by_xfer}) ? lim_by_xfer : page_left[XB:0];
        row_left_dd <= row_left_d;
        last_row_dd <= last_row_d;
        pos.xfer_num    <= num_r;
        pos.last_in_row <= row_left_dd == win_w_t'(num_r);
        pos.last_row    <= last_row_dd;
    end

endmodule

/* scanline/scanline_addr_pipe.sv */
// row_col = start_addr + (frame_y / 8) * full_width + frame_x, 5 cycles
// bank = frame_y mod 8, delayed to line up with row_col
// product is truncated to 22 bits, pitch times rows must stay in memory
`timescale 1ns/1ns
`include "scanline_macros.svh"

module scanline_addr_pipe (
    input  logic                     mclk,
    input  scan_geom_pkg::scan_cfg_t cfg,
    scan_pos_if.addr                 pos
);
    import scan_geom_pkg::*;

    localparam int HB = `SCAN_FRAME_HEIGHT_BITS;

    frame_x_t                    frame_x;           // stage 1
    frame_y_t                    frame_y;
    logic [HB-4:0]               frame_y8;          // stage 2, bank removed
    win_w_t                      full_width_r;
    logic [HB-3+$bits(win_w_t)-1:0] mul_w;
    rc_addr_t                    mul_rslt;          // stage 3
    rc_addr_t                    start_addr_r;
    rc_addr_t                    line_start;        // stage 4
    frame_x_t                    frame_x_d [0:2];
    bank_t                       bank_d [0:3];

    assign mul_w    = frame_y8 * full_width_r;      // maps onto one dsp
    assign pos.bank = bank_d[3];

    always_ff @(posedge mclk) begin
        frame_x      <= pos.curr_x + cfg.window_x0;
        frame_y      <= pos.curr_y + cfg.window_y0;
        frame_y8     <= frame_y[HB-1:3];
        full_width_r <= cfg.frame_full_width;       // absorbed into the dsp input
        mul_rslt     <= mul_w[RC_BITS-1:0];
        start_addr_r <= cfg.start_addr;
        line_start   <= start_addr_r + mul_rslt;
        pos.row_col  <= line_start + rc_addr_t'(frame_x_d[2]);
        frame_x_d[0] <= frame_x;
        bank_d[0]    <= frame_y[2:0];
        for (int i = 1; i < 3; i++)
            frame_x_d[i] <= frame_x_d[i-1];
        for (int i = 1; i < 4; i++)
            bank_d[i] <= bank_d[i-1];
    end

endmodule

/* scanline/scanline_ctrl.sv */
// request FSM of the channel: busy, want/need, free pages, position stepping
// descriptor is trusted only SCAN_PAR_LATENCY cycles after a write or a start
// run_n_reset=0 aborts the frame without frame_done
`timescale 1ns/1ns
`include "scanline_macros.svh"

module scanline_ctrl (
    input  logic                     rst,
    input  logic                     mclk,
    input  scan_cmd_pkg::scan_mode_t mode,
    input  logic                     cfg_write,   // any accepted command write
    input  logic                     frame_start,
    input  logic                     next_page,   // consumer released a page
    input  logic                     suspend,
    input  logic                     xfer_grant,
    input  logic                     xfer_done,
    output logic                     frame_done,
    output logic                     xfer_want,
    output logic                     xfer_need,
    output logic                     xfer_start,
    output logic                     xfer_reset_page,
    scan_pos_if.ctrl                 pos
);
    import scan_geom_pkg::*;

    localparam int LAT = `SCAN_PAR_LATENCY;

    logic                          busy;
    logic                          last_block;  // final transfer already started
    logic [LAT-1:0]                par_mod;     // fills with ones while settling
    logic [2:0]                    free_pages;
    logic [`SCAN_PENDING_BITS-1:0] pending;     // started, not yet done
    logic                          chn_rst;
    logic                          chn_en;
    logic                          calc_valid;
    logic                          pre_want;
    logic                          pages_ok;

    assign chn_rst    = ~mode.run_n_reset;
    assign chn_en     = mode.enable & mode.run_n_reset;
    assign calc_valid = par_mod[LAT-1];
    assign pages_ok   = free_pages > {1'b0, mode.extra_pages};
    assign pre_want   = chn_en && busy && !xfer_want && !xfer_start && calc_valid &&
                        !last_block && !suspend;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            par_mod         <= '0;
            busy            <= 1'b0;
            xfer_start      <= 1'b0;
            xfer_want       <= 1'b0;
            xfer_need       <= 1'b0;
            xfer_reset_page <= 1'b1;                   // mode clears to reset
            frame_done      <= 1'b0;
        end else begin
            if (cfg_write || xfer_start || chn_rst)
                par_mod <= '0;                         // restart settling
            else
                par_mod <= {par_mod[LAT-2:0], 1'b1};

            if (chn_rst || frame_done)
                busy <= 1'b0;
            else if (frame_start)
                busy <= 1'b1;

            xfer_start      <= xfer_grant && !chn_rst; // one cycle after grant
            xfer_reset_page <= chn_rst;

            if (chn_rst || xfer_grant)
                xfer_want <= 1'b0;
            else if (pre_want && pages_ok)
                xfer_want <= 1'b1;

            if (chn_rst || xfer_grant)
                xfer_need <= 1'b0;
            else if (pre_want && pages_ok && (free_pages >= 3'd3))
                xfer_need <= 1'b1;                     // buffer nearly empty

            frame_done <= busy && !chn_rst && last_block && xfer_done &&
                          (pending == `SCAN_PENDING_BITS'(1));
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            free_pages <= '0;
            pending    <= '0;
            last_block <= 1'b0;
        end else begin
            if (frame_start)
                free_pages <= 3'(`SCAN_BUF_PAGES);
            else if (xfer_start && !next_page)
                free_pages <= free_pages - 3'd1;
            else if (!xfer_start && next_page)
                free_pages <= free_pages + 3'd1;

            if (chn_rst || !busy)
                pending <= '0;
            else if (xfer_start && !xfer_done)
                pending <= pending + 1'b1;
            else if (!xfer_start && xfer_done)
                pending <= pending - 1'b1;

            if (chn_rst || !busy)
                last_block <= 1'b0;
            else if (xfer_start && pos.last_row && pos.last_in_row)
                last_block <= 1'b1;
        end
    end

    // every frame starts at the window origin
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            pos.curr_x <= '0;
            pos.curr_y <= '0;
        end else if (chn_rst || frame_start) begin
            pos.curr_x <= '0;
            pos.curr_y <= '0;
        end else if (xfer_start) begin
            pos.curr_x <= pos.last_in_row ? '0 : pos.curr_x + frame_x_t'(pos.xfer_num);
            if (pos.last_in_row)
                pos.curr_y <= pos.curr_y + frame_y_t'(1);
        end
    end

endmodule

/* scanline/scanline_regs.sv */
// parameter and mode registers, written one cycle after cmd_we
// zero width or pitch sets the carry bit (8192), zero height means 65536
// unknown register indices are ignored
`timescale 1ns/1ns
`include "scanline_macros.svh"

module scanline_regs (
    input  logic                      rst,
    input  logic                      mclk,
    input  scan_cmd_pkg::cmd_addr_t   cmd_a,
    input  scan_cmd_pkg::cmd_data_t   cmd_data,
    input  logic                      cmd_we,
    output scan_geom_pkg::scan_cfg_t  cfg,
    output scan_cmd_pkg::scan_mode_t  mode
);
    import scan_geom_pkg::*;
    import scan_cmd_pkg::*;

    localparam int WB = `SCAN_FRAME_WIDTH_BITS;
    localparam int HB = `SCAN_FRAME_HEIGHT_BITS;

    logic lsw_zero; // low half width field all zero
    logic msw_zero; // high half height field all zero

    assign lsw_zero = ~|cmd_data[WB-1:0];
    assign msw_zero = ~|cmd_data[HB+15:16];

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            mode <= '0;   // channel held in reset
            cfg  <= '0;
        end else if (cmd_we) begin
            case (cmd_a)
                MODE:        mode <= scan_mode_t'(cmd_data[3:0]);
                START_ADDR:  cfg.start_addr <= cmd_data[RC_BITS-1:0];
                FULL_WIDTH:  cfg.frame_full_width <= {lsw_zero, cmd_data[WB-1:0]};
                WINDOW_WH: begin
                    cfg.window_width  <= {lsw_zero, cmd_data[WB-1:0]};
                    cfg.window_height <= {msw_zero, cmd_data[HB+15:16]};
                end
                WINDOW_X0Y0: begin
                    cfg.window_x0 <= cmd_data[WB-1:0];
                    cfg.window_y0 <= cmd_data[HB+15:16];
                end
                default: ;    // reserved index
            endcase
        end
    end

endmodule

/* hdl/cmd_deser.sv */
// collects the six command bytes, a new strobe restarts the sequence
// cmd_we pulses one cycle after the sixth byte and only on an address hit
// cmd_a and cmd_data hold until the next command arrives
`timescale 1ns/1ns
`include "scanline_macros.svh"

module cmd_deser (
    input  logic                    rst,
    input  logic                    mclk,
    input  logic [7:0]              cmd_ad,
    input  logic                    cmd_stb,
    output scan_cmd_pkg::cmd_addr_t cmd_a,
    output scan_cmd_pkg::cmd_data_t cmd_data,
    output logic                    cmd_we
);
    logic [2:0]  byte_cnt;  // 0 idle, 1..5 bytes still expected
    logic [47:0] shift_sr;  // first byte ends up in the low byte
    logic [15:0] addr_w;
    logic        last_byte;
    logic        addr_hit;

    assign last_byte = (byte_cnt == 3'd5) && !cmd_stb;
    assign addr_w    = shift_sr[23:8]; // AL, AH before the final shift
    assign addr_hit  = (addr_w & 16'(`SCAN_CMD_MASK)) == (16'(`SCAN_CMD_BASE) & 16'(`SCAN_CMD_MASK));
    assign cmd_a     = shift_sr[3:0];
    assign cmd_data  = shift_sr[47:16];

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            byte_cnt <= '0;
            cmd_we   <= 1'b0;
        end else begin
            cmd_we <= last_byte && addr_hit;
            if (cmd_stb)
                byte_cnt <= 3'd1;                  // AL on the bus
            else if (byte_cnt != '0)
                byte_cnt <= last_byte ? 3'd0 : byte_cnt + 3'd1;
        end
    end

    always_ff @(posedge mclk) begin
        if (cmd_stb || (byte_cnt != '0))
            shift_sr <= {cmd_ad, shift_sr[47:8]};  // shift in from the top
    end

endmodule

/* common/scan_pos_if.sv */
// scan position out of the control, transfer descriptor back from the datapaths
// descriptor lags curr_x/curr_y by the datapath latency
`timescale 1ns/1ns

interface scan_pos_if;
    import scan_geom_pkg::*;

    frame_x_t  curr_x;      // window relative
    frame_y_t  curr_y;
    xfer_len_t xfer_num;    // bursts in the next transfer
    logic      last_in_row; // transfer ends the window line
    logic      last_row;    // curr_y is the last window line
    rc_addr_t  row_col;
    bank_t     bank;

    modport ctrl (output curr_x, curr_y, input xfer_num, last_in_row, last_row);
    modport len  (input curr_x, curr_y, output xfer_num, last_in_row, last_row);
    modport addr (input curr_x, curr_y, output row_col, bank);

endinterface

/* common/scan_cmd_pkg.sv */
// byte-serial command protocol types
// a command is AL, AH, D0..D3 with the strobe on AL
// only the low address nibble reaches the register decoder

package scan_cmd_pkg;

    typedef logic [3:0]  cmd_addr_t;
    typedef logic [31:0] cmd_data_t;

    typedef enum cmd_addr_t {
        MODE        = 4'h0,  // {extra_pages, enable, run_n_reset}
        START_ADDR  = 4'h2,  // 22-bit {row, col8}
        FULL_WIDTH  = 4'h3,  // line pitch, 0 means 8192
        WINDOW_WH   = 4'h4,  // width low half, height high half
        WINDOW_X0Y0 = 4'h5   // left low half, top high half
    } scan_reg_e;

    typedef struct packed {
        logic [1:0] extra_pages; // consumer holds more than one page
        logic       enable;
        logic       run_n_reset; // 0 holds the channel in reset
    } scan_mode_t;

endpackage

/* common/scan_geom_pkg.sv */
// frame and ddr3 geometry types
// widths come from scanline_macros.svh
// window width and height carry one extra bit, so zero programs the maximum
`include "scanline_macros.svh"

package scan_geom_pkg;

    localparam int RC_BITS = `SCAN_ADDRESS_NUMBER + `SCAN_COLADDR_NUMBER - 3; // 22

    typedef logic [RC_BITS-1:0]                  rc_addr_t;  // {row, col8}
    typedef logic [`SCAN_FRAME_WIDTH_BITS-1:0]   frame_x_t;
    typedef logic [`SCAN_FRAME_HEIGHT_BITS-1:0]  frame_y_t;
    typedef logic [`SCAN_FRAME_WIDTH_BITS:0]     win_w_t;    // msb set means 8192
    typedef logic [`SCAN_FRAME_HEIGHT_BITS:0]    win_h_t;    // msb set means 65536
    typedef logic [`SCAN_XFER_BITS:0]            xfer_len_t; // 1..64 bursts
    typedef logic [2:0]                          bank_t;

    typedef struct packed {
        rc_addr_t start_addr;       // frame origin, bank 0
        win_w_t   frame_full_width; // line pitch in 8-bursts
        win_w_t   window_width;
        win_h_t   window_height;
        frame_x_t window_x0;
        frame_y_t window_y0;
    } scan_cfg_t;

endpackage

/* common/scanline_macros.svh */
// geometry and timing constants for the scan-line sequencer
// memory page is 2**(SCAN_COLADDR_NUMBER-3) = 128 bursts of 8
// SCAN_PAR_LATENCY must cover the slower datapath (5 cycles)
`ifndef SCANLINE_MACROS_SVH
`define SCANLINE_MACROS_SVH

`define SCAN_ADDRESS_NUMBER    15     // ddr3 row bits
`define SCAN_COLADDR_NUMBER    10     // ddr3 column bits, 3 lsbs always 0
`define SCAN_XFER_BITS         6      // longest transfer 64 bursts
`define SCAN_FRAME_WIDTH_BITS  13     // frame width in 8-bursts
`define SCAN_FRAME_HEIGHT_BITS 16     // frame height in lines
`define SCAN_PAR_LATENCY       7      // settle cycles after write or start
`define SCAN_PENDING_BITS      2      // started but unfinished transfers
`define SCAN_CMD_BASE          'h120  // command address of this channel
`define SCAN_CMD_MASK          'h3f0  // low 4 bits select the register
`define SCAN_BUF_PAGES         4      // free pages at frame start

`endif
